// File: design/rename_cfg_pkg.sv
package rename_cfg_pkg;

	// Register file sizes
	localparam int NUM_ARCH_REG = 16;
	localparam int NUM_PHYS_REG = 32;

	// Widest retire bundle the forwarding logic is written for
	localparam int RETIRE_WIDTH_MAX = 4;

	// Bits needed to name one physical register
	localparam int PREG_W = $clog2(NUM_PHYS_REG);

	// Physical register index
	typedef logic [PREG_W-1:0] phys_reg_t;

	// Committed mapping, entry i holds the physical register of arch register i
	typedef phys_reg_t [NUM_ARCH_REG-1:0] arch_map_t;

	// One bit per physical register, set when the register is free
	typedef logic [NUM_PHYS_REG-1:0] phys_mask_t;

endpackage

// File: design/retire_pkg.sv
package retire_pkg;

	import rename_cfg_pkg::*;

	// One retiring instruction
	typedef struct packed {
		logic      valid;
		phys_reg_t t_new; // Register written by the instruction
		phys_reg_t t_old; // Register it supersedes, released at retire
	} retire_lane_t;

	// Rename stage taking a register off the free list
	typedef struct packed {
		logic      valid;
		phys_reg_t preg;
	} alloc_req_t;

	// Rebuilt state handed out after a flush
	typedef struct packed {
		arch_map_t         map;
		phys_mask_t        free_mask;
		logic [PREG_W:0]   free_count; // Needs one extra bit, all registers may be free
	} recovery_t;

endpackage

// File: design/map_match_cam.sv
module map_match_cam #(
	parameter int RETIRE_WIDTH = 2
) (
	input  rename_cfg_pkg::arch_map_t                          entries,
	input  rename_cfg_pkg::phys_reg_t [RETIRE_WIDTH-1:0]       tags,
	input  logic [RETIRE_WIDTH-1:0]                            tag_valid,
	output logic [rename_cfg_pkg::NUM_ARCH_REG-1:0][RETIRE_WIDTH-1:0] hits
);

	import rename_cfg_pkg::*;

	// Every entry against every tag, all in parallel
	always_comb begin
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			for (int j = 0; j < RETIRE_WIDTH; j++) begin
				hits[i][j] = tag_valid[j] && (entries[i] == tags[j]);
			end
		end
	end

endmodule

// File: design/arch_map_table.sv
module arch_map_table #(
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                          clock,
	input  logic                                          reset,
	input  retire_pkg::retire_lane_t [RETIRE_WIDTH-1:0]   retire,
	output rename_cfg_pkg::arch_map_t                     arch_map
);

	import rename_cfg_pkg::*;

	phys_reg_t [RETIRE_WIDTH-1:0]              fwd_old;   // Tag each lane searches for
	logic [RETIRE_WIDTH-1:0]                   fwd_valid; // Lanes left after chain folding
	logic [NUM_ARCH_REG-1:0][RETIRE_WIDTH-1:0] hits;
	arch_map_t                                 map_next;

	if (RETIRE_WIDTH < 1 || RETIRE_WIDTH > RETIRE_WIDTH_MAX) begin : g_width_check
		$error("arch_map_table: RETIRE_WIDTH %0d outside 1..%0d",
			RETIRE_WIDTH, RETIRE_WIDTH_MAX);
	end

	// Chain folding.
	// A lane whose t_old is the t_new of an older lane in the bundle does not
	// exist in the map yet, so it walks back to the entry the chain started
	// from and carries its own t_new there. The older lane it supersedes is
	// dropped, since its write would be overwritten in the same cycle anyway
	always_comb begin
		for (int k = 0; k < RETIRE_WIDTH; k++) begin
			fwd_old[k]   = retire[k].t_old;
			fwd_valid[k] = retire[k].valid;

			// Youngest to oldest, so multi-step chains resolve in one pass
			for (int j = k - 1; j >= 0; j--) begin
				if (retire[j].valid && (fwd_old[k] == retire[j].t_new)) begin
					fwd_old[k] = retire[j].t_old;
				end
			end

			for (int m = k + 1; m < RETIRE_WIDTH; m++) begin
				if (retire[m].valid && (retire[m].t_old == retire[k].t_new)) begin
					fwd_valid[k] = 1'b0; // Superseded within the bundle
				end
			end
		end
	end

	map_match_cam #(
		.RETIRE_WIDTH(RETIRE_WIDTH)
	) map_match_cam_i (
		.entries  (arch_map),
		.tags     (fwd_old),
		.tag_valid(fwd_valid),
		.hits     (hits)
	);

	// Later lanes override earlier ones on the same entry
	always_comb begin
		map_next = arch_map;
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			for (int j = 0; j < RETIRE_WIDTH; j++) begin
				if (hits[i][j]) begin
					map_next[i] = retire[j].t_new;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REG; i++) begin
				arch_map[i] <= phys_reg_t'(i); // Identity mapping
			end
		end else begin
			arch_map <= map_next;
		end
	end

endmodule

// File: design/phys_free_tracker.sv
module phys_free_tracker #(
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                          clock,
	input  logic                                          reset,
	input  retire_pkg::alloc_req_t                        alloc,
	input  retire_pkg::retire_lane_t [RETIRE_WIDTH-1:0]   retire,
	input  retire_pkg::recovery_t                         recovery,
	input  logic                                          recovery_valid,
	output rename_cfg_pkg::phys_mask_t                    free_mask
);

	import rename_cfg_pkg::*;

	// Arch registers start mapped to the low physical registers
	localparam phys_mask_t RESET_MASK = {
		{(NUM_PHYS_REG - NUM_ARCH_REG){1'b1}},
		{NUM_ARCH_REG{1'b0}}
	};

	phys_mask_t mask_next;

	always_comb begin
		mask_next = free_mask;

		if (alloc.valid) begin
			mask_next[alloc.preg] = 1'b0;
		end

		// Releases come after the allocation so a release wins
		for (int j = 0; j < RETIRE_WIDTH; j++) begin
			if (retire[j].valid) begin
				mask_next[retire[j].t_old] = 1'b1;
			end
		end

		if (recovery_valid) begin
			mask_next = recovery.free_mask; // Rebuilt mask replaces everything
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			free_mask <= RESET_MASK;
		end else begin
			free_mask <= mask_next;
		end
	end

endmodule

// File: design/flush_recovery_builder.sv
module flush_recovery_builder (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       flush,
	input  rename_cfg_pkg::arch_map_t  arch_map,
	output retire_pkg::recovery_t      recovery,
	output logic                       recovery_valid
);

	import rename_cfg_pkg::*;

	phys_mask_t      referenced;
	phys_mask_t      rebuilt_mask;
	logic [PREG_W:0] rebuilt_count;

	// A physical register is free exactly when no arch entry points at it
	always_comb begin
		referenced = '0;
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			referenced[arch_map[i]] = 1'b1;
		end
		rebuilt_mask = ~referenced;
	end

	always_comb begin
		rebuilt_count = '0;
		for (int p = 0; p < NUM_PHYS_REG; p++) begin
			rebuilt_count = rebuilt_count + (PREG_W + 1)'(rebuilt_mask[p]);
		end
	end

	// Packet is captured only on a flush and held until the next one
	always_ff @(posedge clock) begin
		if (flush) begin
			recovery.map        <= arch_map;
			recovery.free_mask  <= rebuilt_mask;
			recovery.free_count <= rebuilt_count;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			recovery_valid <= 1'b0;
		end else begin
			recovery_valid <= flush; // One cycle pulse per flush
		end
	end

endmodule

// File: design/retire_rename_top.sv
module retire_rename_top #(
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                          clock,
	input  logic                                          reset,
	input  retire_pkg::retire_lane_t [RETIRE_WIDTH-1:0]   retire,
	input  retire_pkg::alloc_req_t                        alloc,
	input  logic                                          flush,
	output rename_cfg_pkg::arch_map_t                     arch_map,
	output rename_cfg_pkg::phys_mask_t                    free_mask,
	output retire_pkg::recovery_t                         recovery,
	output logic                                          recovery_valid
);

	// Committed map, updated by retiring lanes
	arch_map_table #(
		.RETIRE_WIDTH(RETIRE_WIDTH)
	) arch_map_table_i (
		.clock   (clock),
		.reset   (reset),
		.retire  (retire),
		.arch_map(arch_map)
	);

	// Free list, reloaded from the recovery packet after a flush
	phys_free_tracker #(
		.RETIRE_WIDTH(RETIRE_WIDTH)
	) phys_free_tracker_i (
		.clock         (clock),
		.reset         (reset),
		.alloc         (alloc),
		.retire        (retire),
		.recovery      (recovery),
		.recovery_valid(recovery_valid),
		.free_mask     (free_mask)
	);

	flush_recovery_builder flush_recovery_builder_i (
		.clock         (clock),
		.reset         (reset),
		.flush         (flush),
		.arch_map      (arch_map),
		.recovery      (recovery),
		.recovery_valid(recovery_valid)
	);

endmodule

// File: tests/retire_rename_checker.sv
module retire_rename_checker #(
	parameter int RETIRE_WIDTH = 2
) (
	input logic                                        clock,
	input logic                                        reset,
	input retire_pkg::retire_lane_t [RETIRE_WIDTH-1:0] retire,
	input retire_pkg::alloc_req_t                      alloc,
	input logic                                        flush,
	input rename_cfg_pkg::phys_mask_t                  free_mask,
	input retire_pkg::recovery_t                       recovery,
	input logic                                        recovery_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	logic idle;
	int failures = 0; // Failed assertions so far

	always_comb begin
		idle = !alloc.valid;
		for (int j = 0; j < RETIRE_WIDTH; j++) idle &= !retire[j].valid;
	end

	// No traffic in the flush cycle or the one after
	a_flush_idle: assert property (@(posedge clock) disable iff (reset)
		flush |-> idle ##1 idle)
		else begin
			$error("Traffic during flush window");
			failures++;
		end

	// Exactly one cycle of recovery_valid per flush
	a_valid_after_flush: assert property (@(posedge clock) disable iff (reset)
		flush |=> recovery_valid ##1 !recovery_valid)
		else begin
			$error("recovery_valid not a single cycle after flush");
			failures++;
		end

	a_valid_only_after_flush: assert property (@(posedge clock) disable iff (reset)
		recovery_valid |-> $past(flush))
		else begin
			$error("Stray recovery_valid");
			failures++;
		end

	a_reload: assert property (@(posedge clock) disable iff (reset)
		recovery_valid |=> free_mask == $past(recovery.free_mask))
		else begin
			$error("Free mask not reloaded");
			failures++;
		end

	a_count: assert property (@(posedge clock) disable iff (reset)
		recovery_valid |-> recovery.free_count == $countones(recovery.free_mask))
		else begin
			$error("Free count wrong");
			failures++;
		end

endmodule

bind retire_rename_top retire_rename_checker #(
	.RETIRE_WIDTH(RETIRE_WIDTH)
) retire_rename_checker_i (.*);

// File: tests/retire_rename_tb.sv
module retire_rename_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rename_cfg_pkg::*;
	import retire_pkg::*;

	localparam int RETIRE_WIDTH = 2;
	localparam int N_SINGLE = 60;
	localparam int N_FULL = 60;
	localparam int N_CHAIN = 40;
	localparam int N_ALLOC = 30;  // Two cycles each
	localparam int N_FLUSH = 8;   // Ten traffic cycles, a flush and two idle cycles each
	localparam int TOTAL_CYCLES = 8 + N_SINGLE + N_FULL + N_CHAIN + 2 * N_ALLOC + 13 * N_FLUSH;

	logic clock = 1'b0;
	logic reset;
	retire_lane_t [RETIRE_WIDTH-1:0] retire;
	alloc_req_t alloc;
	logic flush;
	arch_map_t arch_map;
	phys_mask_t free_mask;
	recovery_t recovery;
	logic recovery_valid;

	// Reference model state, already advanced to what the DUT shows after the next edge
	arch_map_t exp_map;
	phys_mask_t exp_mask;
	recovery_t exp_rec;
	logic exp_rv;
	logic checking = 1'b0;
	logic [15:0] lfsr = 16'd6;
	string test_name = "reset";
	int mismatches = 0;

	retire_rename_top #(
		.RETIRE_WIDTH(RETIRE_WIDTH)
	) retire_rename_top_i (.*);

	always #5 clock = ~clock;

	// Taps 16 14 13 11
	function automatic int take_bits(input int n);
		int v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	// Sequential update rule, lane 0 first, allocation before releases
	function automatic void apply_bundle(inout arch_map_t m, inout phys_mask_t f,
			input retire_lane_t [RETIRE_WIDTH-1:0] lanes, input alloc_req_t a);
		if (a.valid) f[a.preg] = 1'b0;
		for (int j = 0; j < RETIRE_WIDTH; j++) begin
			if (lanes[j].valid) begin
				for (int i = 0; i < NUM_ARCH_REG; i++) begin
					if (m[i] == lanes[j].t_old) m[i] = lanes[j].t_new;
				end
				f[lanes[j].t_old] = 1'b1;
			end
		end
	endfunction

	// Free is whatever the map does not point at
	function automatic recovery_t rebuild(input arch_map_t m);
		recovery_t r;
		r.map = m;
		r.free_mask = '1;
		r.free_count = '0;
		for (int i = 0; i < NUM_ARCH_REG; i++) r.free_mask[m[i]] = 1'b0;
		for (int p = 0; p < NUM_PHYS_REG; p++) r.free_count += r.free_mask[p];
		return r;
	endfunction

	function automatic logic in_map(input arch_map_t m, input int p);
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			if (m[i] == p) return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH test=%s %s expected=%h actual=%h", test_name, what, exp, act);
			$display("Verification failed");
			$fatal(1, "Output differs from the reference model");
		end
	endtask

	// Unmapped register not yet used in this bundle
	task automatic pick_new(inout phys_mask_t avoid, output phys_reg_t r);
		int v;
		do begin
			v = take_bits(PREG_W);
		end while (in_map(exp_map, v) || avoid[v]);
		avoid[v] = 1'b1;
		r = phys_reg_t'(v);
	endtask

	// Mode 0 one lane, 1 full width on distinct entries, 2 chained lanes
	task automatic build_bundle(input int mode, output retire_lane_t [RETIRE_WIDTH-1:0] lanes);
		phys_mask_t avoid = '0;
		logic [NUM_ARCH_REG-1:0] used_arch = '0;
		int v;
		int sel;
		lanes = '0;
		sel = take_bits($clog2(RETIRE_WIDTH) + 1);
		for (int j = 0; j < RETIRE_WIDTH; j++) begin
			if (mode == 0 && j != sel % RETIRE_WIDTH) continue;
			lanes[j].valid = 1'b1;
			if (mode == 2 && j > 0) begin
				lanes[j].t_old = lanes[j-1].t_new;
			end else begin
				do begin
					v = take_bits(4);
				end while (used_arch[v]);
				used_arch[v] = 1'b1;
				lanes[j].t_old = exp_map[v];
			end
			pick_new(avoid, lanes[j].t_new);
		end
	endtask

	task automatic step(input retire_lane_t [RETIRE_WIDTH-1:0] lanes, input alloc_req_t a,
			input logic fl);
		@(negedge clock);
		retire = lanes;
		alloc = a;
		flush = fl;
		if (exp_rv) begin
			exp_mask = exp_rec.free_mask;
			exp_rv = 1'b0;
		end
		if (fl) begin
			exp_rec = rebuild(exp_map);
			exp_rv = 1'b1;
		end else begin
			apply_bundle(exp_map, exp_mask, lanes, a);
		end
	endtask

	task automatic run_bundles(input string name, input int mode, input int n);
		retire_lane_t [RETIRE_WIDTH-1:0] lanes;
		test_name = name;
		for (int c = 0; c < n; c++) begin
			build_bundle(mode, lanes);
			step(lanes, '0, 1'b0);
		end
	endtask

	initial begin : compare
		forever begin
			@(posedge clock);
			#1;
			if (checking) begin
				check("arch_map", exp_map, arch_map);
				check("free_mask", exp_mask, free_mask);
				check("recovery_valid", exp_rv, recovery_valid);
				if (exp_rv) begin
					check("recovery.map", exp_rec.map, recovery.map);
					check("recovery.free_mask", exp_rec.free_mask, recovery.free_mask);
					check("recovery.free_count", exp_rec.free_count, recovery.free_count);
				end
			end
		end
	end

	initial begin : watchdog
		#((TOTAL_CYCLES + 50) * 10);
		$display("Timeout, the test sequence did not finish in time");
		$display("Verification failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin : stimulus
		retire_lane_t [RETIRE_WIDTH-1:0] lanes;
		alloc_req_t a;
		phys_mask_t avoid;
		reset = 1'b1;
		retire = '0;
		alloc = '0;
		flush = 1'b0;
		exp_rv = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < NUM_ARCH_REG; i++) exp_map[i] = phys_reg_t'(i);
		for (int p = 0; p < NUM_PHYS_REG; p++) exp_mask[p] = (p >= NUM_ARCH_REG);
		checking = 1'b1;
		step('0, '0, 1'b0);

		run_bundles("single_lane", 0, N_SINGLE);
		run_bundles("full_width", 1, N_FULL);
		run_bundles("chain", 2, N_CHAIN);

		test_name = "alloc_release";
		for (int c = 0; c < N_ALLOC; c++) begin
			avoid = '0;
			a.valid = 1'b1;
			pick_new(avoid, a.preg);
			step('0, a, 1'b0);
			build_bundle(c % 2, lanes);
			if (c % 3 == 0) begin
				for (int j = 0; j < RETIRE_WIDTH; j++) begin
					if (lanes[j].valid) a.preg = lanes[j].t_old; // Same register both ways
				end
			end else begin
				pick_new(avoid, a.preg);
			end
			step(lanes, a, 1'b0);
		end

		test_name = "flush_recovery";
		for (int r = 0; r < N_FLUSH; r++) begin
			for (int c = 0; c < 10; c++) begin
				build_bundle(c % 3, lanes);
				a.valid = c[0];
				avoid = '0;
				pick_new(avoid, a.preg);
				step(lanes, a, 1'b0);
			end
			step('0, '0, 1'b1);
			step('0, '0, 1'b0);
			step('0, '0, 1'b0);
		end

		step('0, '0, 1'b0);
		@(posedge clock);
		#2;
		if (mismatches == 0 && retire_rename_top_i.retire_rename_checker_i.failures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: tb.f
design/rename_cfg_pkg.sv
design/retire_pkg.sv
design/map_match_cam.sv
design/arch_map_table.sv
design/phys_free_tracker.sv
design/flush_recovery_builder.sv
design/retire_rename_top.sv
tests/retire_rename_checker.sv
tests/retire_rename_tb.sv

// File: Bender.yml
package:
  name: retire_rename

sources:
  - files:
      - design/rename_cfg_pkg.sv
      - design/retire_pkg.sv
      - design/map_match_cam.sv
      - design/arch_map_table.sv
      - design/phys_free_tracker.sv
      - design/flush_recovery_builder.sv
      - design/retire_rename_top.sv
  - target: test
    files:
      - tests/retire_rename_checker.sv
      - tests/retire_rename_tb.sv
